/* bench/h80_cases.txt */
// per case, all hex: word count then program words / check count then register-value pairs
// then expected flags (overflow sign zero carry); a word count of 0 ends the list
// reset state, NOPs then HALT, every register zero
03 0000 0000 0001
10 0 0000 1 0000 2 0000 3 0000 4 0000 5 0000 6 0000 7 0000
   8 0000 9 0000 a 0000 b 0000 c 0000 d 0000 e 0000 f 0000
0
// low and high byte immediates
06 1134 2112 22ab 12cd 1156 0001
03 1 1256 2 abcd 3 0000
0
// ADD with overflow, ADD with carry, ADC, SUB with overflow
09 11ff 217f 1201 2380 8612 8733 a822 9932 0001
05 1 7fff 6 8000 7 0000 8 0003 9 7fff
8
// CP borrow feeds SBC, then AND OR XOR with parity
0a 14f0 24f0 15f0 250f f054 ba45 cb45 dc45 ed45 0001
05 0 0000 a e0ff b 00f0 c fff0 d ff00
c
// word stores and loads at two addresses
0c 1134 2112 12ef 22be 2301 2401 1402 3213 3224 3053 3064 0001
03 5 1234 6 beef 1 1234
0
// countdown loop, JPN taken and not, JP C not taken, JP Z taken, code after HALT
0e 1103 1201 1405 1a0a 1b16 8334 9112 031a 034a 035b 1cff 1d77 0001 1e55
05 1 0000 3 000f c 0000 d 0077 e 0000
2
0

/* bench/h80_top_sva.sv */
`timescale 1ns/1ps

module h80_top_sva (
   input logic clk,
   input logic reset,
   input logic run,
   input logic done,
   input logic halted
);

   int run_errs  = 0;
   int done_errs = 0;
   int halt_errs = 0;
   int fail_count;

   assign fail_count = run_errs + done_errs + halt_errs;   // read by the testbench

   run_held: assert property (@(posedge clk) disable iff (reset)
      (run != done) |=> $stable(run))
      else begin
         $error("run toggled while a request was outstanding");
         run_errs++;
      end

   done_prompt: assert property (@(posedge clk) disable iff (reset)
      (run != done) |=> (run == done))
      else begin
         $error("done did not answer one cycle after the request");
         done_errs++;
      end

   // no more bus traffic once the core has stopped
   halt_sticky: assert property (@(posedge clk) disable iff (reset)
      halted |=> (halted && $stable(run)))
      else begin
         $error("halted dropped or run toggled after halt");
         halt_errs++;
      end

endmodule

/* bench/h80_top_tb.sv */
`timescale 1ns/1ps

module h80_top_tb;

   localparam int half_period = 20;
   localparam int case_len    = 512;

   logic               clk;
   logic               reset;
   logic               load_we;
   cpu_pkg::bus_addr_t load_addr;
   cpu_pkg::word_t     load_data;
   cpu_pkg::reg_num_t  dbg_sel;
   cpu_pkg::word_t     dbg_data;
   cpu_pkg::flags_t    flags;
   logic               halted;

   logic [15:0] case_data [case_len];   // image of the cases file
   int          pos;
   int          cycles;
   int          cycle_limit;

   h80_top #(.mem_words(4096)) uut (
      .clk, .reset, .load_we, .load_addr, .load_data,
      .dbg_sel, .dbg_data, .flags, .halted
   );

   bind h80_top h80_top_sva bus_checks (
      .clk(clk), .reset(reset), .run(bus.run), .done(bus.done), .halted(halted)
   );

   always #(half_period) clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (uut.bus_checks.fail_count != 0) begin
         $display("a bus or halt assertion failed at %0d ns", $time);
         $display("test failed");
         $fatal(1, "assertion failure");
      end else if (cycles >= cycle_limit) begin
         $display("timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("test failed");
         $fatal(1, "cycle limit reached");
      end
   end

   task automatic expect_equal(input string name, input logic [15:0] got,
                               input logic [15:0] want);
      if (got !== want) begin
         $display("[FAIL] time %0d ns, %s: got %h, expected %h", $time, name, got, want);
         $display("test failed");
         $fatal(1, "value mismatch");
      end
   endtask

   // 4 cycles per program word and 20 per case
   function automatic int cycle_budget();
      int p;
      int total;
      int words;
      p = 0;
      total = 0;
      while (p < case_len && !$isunknown(case_data[p]) && case_data[p] != 0) begin
         words = case_data[p];
         total += 4 * words + 20;
         p += words + 1;
         p += 2 * case_data[p] + 2;   // check count, pairs, flags
      end
      return total;
   endfunction

   // reset stays high for at least 3 cycles, longer for long programs
   task automatic load_program(input int words);
      @(posedge clk);
      reset <= 1'b1;
      for (int i = 0; i < words || i < 3; i++) begin
         load_we   <= i < words;
         load_addr <= cpu_pkg::bus_addr_t'(2 * i);
         load_data <= case_data[pos + i];
         @(posedge clk);
      end
      load_we <= 1'b0;
      reset   <= 1'b0;
   endtask

   task automatic run_case(input int num);
      int    words;
      int    checks;
      string name;
      words = case_data[pos];
      pos = pos + 1;
      load_program(words);
      pos = pos + words;
      @(negedge clk);
      expect_equal($sformatf("case %0d halted after reset", num), halted, 16'h0000);
      expect_equal($sformatf("case %0d flags after reset", num), flags, 16'h0000);
      while (halted !== 1'b1) begin
         @(negedge clk);
      end
      checks = case_data[pos];
      pos = pos + 1;
      for (int i = 0; i < checks; i++) begin
         @(posedge clk);
         dbg_sel <= case_data[pos][3:0];
         @(negedge clk);
         name = $sformatf("case %0d dbg_data r%0d", num, case_data[pos][3:0]);
         expect_equal(name, dbg_data, case_data[pos + 1]);
         pos = pos + 2;
      end
      expect_equal($sformatf("case %0d flags", num), flags, case_data[pos]);
      pos = pos + 1;
   endtask

   initial begin
      int num;
      clk       = 1'b0;
      reset     = 1'b1;
      load_we   = 1'b0;
      load_addr = '0;
      load_data = '0;
      dbg_sel   = '0;
      cycles    = 0;
      pos       = 0;
      num       = 0;
      $readmemh("bench/h80_cases.txt", case_data);
      if ($isunknown(case_data[0])) begin
         $display("the cases file bench/h80_cases.txt could not be read");
         $display("test failed");
         $fatal(1, "no stimulus");
      end else begin
         cycle_limit = cycle_budget();
         while (!$isunknown(case_data[pos]) && case_data[pos] != 0) begin
            num = num + 1;
            run_case(num);
         end
         if (uut.bus_checks.fail_count == 0) begin
            $display("test passed");
            $finish;
         end else begin
            $display("%0d bus or halt assertions failed", uut.bus_checks.fail_count);
            $display("test failed");
            $fatal(1, "assertion failure");
         end
      end
   end

endmodule

/* h80_top.f */
logic/cpu_pkg.sv
logic/mem_bus_if.sv
logic/alu.sv
logic/reg_file.sv
logic/cpu_sequencer.sv
logic/word_memory.sv
logic/h80_top.sv
bench/h80_top_sva.sv
bench/h80_top_tb.sv

/* logic/alu.sv */
`timescale 1ns/1ps

module alu (
   input  cpu_pkg::alu_op_t op,
   input  cpu_pkg::word_t   a,
   input  cpu_pkg::word_t   b,
   input  logic             carry_in,
   output cpu_pkg::word_t   result,
   output cpu_pkg::flags_t  flags_out
);

   logic [16:0] sum;
   logic [16:0] ext_a;
   logic [16:0] ext_b;
   logic [16:0] ext_c;
   logic        is_logic;
   logic        is_add;

   assign ext_a = {1'b0, a};
   assign ext_b = {1'b0, b};
   assign ext_c = {16'h0000, carry_in};

   assign is_logic = (op == cpu_pkg::alu_and) || (op == cpu_pkg::alu_or) ||
                     (op == cpu_pkg::alu_xor);
   assign is_add   = (op == cpu_pkg::alu_add) || (op == cpu_pkg::alu_adc);

   always_comb begin
      case (op)
         cpu_pkg::alu_add: sum = ext_a + ext_b;
         cpu_pkg::alu_sub: sum = ext_a - ext_b;
         cpu_pkg::alu_adc: sum = ext_a + ext_b + ext_c;
         cpu_pkg::alu_sbc: sum = ext_a - ext_b - ext_c;   // bit 16 is the borrow
         cpu_pkg::alu_and: sum = ext_a & ext_b;
         cpu_pkg::alu_or:  sum = ext_a | ext_b;
         cpu_pkg::alu_xor: sum = ext_a ^ ext_b;
         default:          sum = ext_a - ext_b;           // CP
      endcase
   end

   assign result = sum[15:0];

   always_comb begin
      flags_out = '0;
      flags_out[cpu_pkg::flag_sign] = sum[15];
      flags_out[cpu_pkg::flag_zero] = (sum[15:0] == 16'h0000);
      if (is_logic) begin
         flags_out[cpu_pkg::flag_overflow] = ~^sum[15:0];   // even parity
         flags_out[cpu_pkg::flag_carry]    = 1'b0;
      end else if (is_add) begin
         flags_out[cpu_pkg::flag_overflow] = (a[15] == b[15]) && (a[15] != sum[15]);
         flags_out[cpu_pkg::flag_carry]    = sum[16];
      end else begin
         flags_out[cpu_pkg::flag_overflow] = (a[15] != b[15]) && (a[15] != sum[15]);
         flags_out[cpu_pkg::flag_carry]    = sum[16];
      end
   end

endmodule

/* logic/cpu_pkg.sv */
package cpu_pkg;

   localparam int word_w    = 16;
   localparam int addr_w    = 16;
   localparam int reg_num_w = 4;
   localparam int flags_w   = 4;
   localparam int num_regs  = 16;

   typedef logic [word_w-1:0]    word_t;
   typedef logic [addr_w-1:0]    bus_addr_t;
   typedef logic [reg_num_w-1:0] reg_num_t;
   typedef logic [word_w-1:0]    ins_t;
   typedef logic [flags_w-1:0]   flags_t;

   // bit positions inside flags_t
   localparam int flag_carry    = 0;
   localparam int flag_zero     = 1;
   localparam int flag_sign     = 2;
   localparam int flag_overflow = 3;

   // instruction field positions (low bit of each field)
   localparam int fld_op_lo    = 12;   // top nibble
   localparam int fld_dst_lo   = 8;    // destination register
   localparam int fld_a_lo     = 4;    // first operand / data register
   localparam int fld_b_lo     = 0;    // second operand / address register
   localparam int fld_cmd_lo   = 9;    // bus t-field
   localparam int fld_sel_bit  = 8;    // bus select, only memory is kept
   localparam int fld_flag_lo  = 4;    // flag number of a jump
   localparam int fld_cond_bit = 6;    // 1 = JP f, 0 = JPN f
   localparam int fld_jp_lo    = 7;
   localparam int fld_alu_bit  = 15;

   // opcodes of the kept encodings
   localparam logic [3:0] op_imm_lo = 4'h1;
   localparam logic [3:0] op_imm_hi = 4'h2;
   localparam logic [3:0] op_bus    = 4'h3;
   localparam ins_t       ins_halt  = 16'h0001;
   localparam logic [8:0] jp_prefix = 9'b0000_0011_0;

   typedef enum logic [2:0] {
      bus_cmd_read_w  = 3'd0,
      bus_cmd_write_w = 3'd1
   } bus_cmd_t;

   // numbered like the top instruction nibble
   typedef enum logic [3:0] {
      alu_add = 4'h8,
      alu_sub = 4'h9,
      alu_adc = 4'ha,
      alu_sbc = 4'hb,
      alu_and = 4'hc,
      alu_or  = 4'hd,
      alu_xor = 4'he,
      alu_cp  = 4'hf
   } alu_op_t;

   typedef enum logic [1:0] {
      st_fetch_wait,
      st_execute,
      st_bus_wait,
      st_halted
   } seq_state_t;

endpackage

/* logic/cpu_sequencer.sv */
`timescale 1ns/1ps

module cpu_sequencer (
   input  logic              clk,
   input  logic              reset,
   mem_bus_if.requester      bus,
   output cpu_pkg::reg_num_t rd_num_a,
   output cpu_pkg::reg_num_t rd_num_b,
   output cpu_pkg::reg_num_t wr_num,
   input  cpu_pkg::word_t    rd_data_a,
   input  cpu_pkg::word_t    rd_data_b,
   output logic              wr_en,
   output cpu_pkg::word_t    wr_data,
   output cpu_pkg::alu_op_t  alu_op,
   input  cpu_pkg::word_t    alu_result,
   input  cpu_pkg::flags_t   alu_flags,
   output cpu_pkg::flags_t   flags,
   output logic              halted
);

   cpu_pkg::seq_state_t state;
   cpu_pkg::bus_addr_t  pc;
   cpu_pkg::bus_addr_t  pc_next;
   cpu_pkg::ins_t       ins;
   cpu_pkg::ins_t       ir;         // held for the data access phase
   logic [3:0]          op;
   logic                busy;
   logic                is_halt;
   logic                is_jump;
   logic                take_jump;
   logic                is_alu;
   logic                is_imm;
   logic                is_mem;
   logic                is_load_ir;

   // word access on the memory bus with command c
   function automatic logic mem_op(cpu_pkg::ins_t i, cpu_pkg::bus_cmd_t c);
      return (i[cpu_pkg::fld_op_lo +: 4] == cpu_pkg::op_bus) &&
             !i[cpu_pkg::fld_sel_bit] && (i[cpu_pkg::fld_cmd_lo +: 3] == c);
   endfunction

   assign busy       = bus.run != bus.done;
   assign ins        = bus.rd_data;       // fetched word stays on rd_data
   assign op         = ins[cpu_pkg::fld_op_lo +: 4];
   assign is_halt    = ins == cpu_pkg::ins_halt;
   assign is_jump    = ins[15:cpu_pkg::fld_jp_lo] == cpu_pkg::jp_prefix;
   assign take_jump  = is_jump &&
                       (flags[ins[cpu_pkg::fld_flag_lo +: 2]] == ins[cpu_pkg::fld_cond_bit]);
   assign is_alu     = ins[cpu_pkg::fld_alu_bit];
   assign is_imm     = (op == cpu_pkg::op_imm_lo) || (op == cpu_pkg::op_imm_hi);
   assign is_mem     = mem_op(ins, cpu_pkg::bus_cmd_read_w) ||
                       mem_op(ins, cpu_pkg::bus_cmd_write_w);
   assign is_load_ir = mem_op(ir, cpu_pkg::bus_cmd_read_w);
   assign pc_next    = take_jump ? rd_data_b : pc + 16'd2;

   assign rd_num_a = is_imm ? ins[cpu_pkg::fld_dst_lo +: 4] : ins[cpu_pkg::fld_a_lo +: 4];
   assign rd_num_b = ins[cpu_pkg::fld_b_lo +: 4];
   assign alu_op   = cpu_pkg::alu_op_t'(op);
   assign halted   = state == cpu_pkg::st_halted;

   always_comb begin
      wr_en   = 1'b0;
      wr_num  = ins[cpu_pkg::fld_dst_lo +: 4];
      wr_data = alu_result;
      if (state == cpu_pkg::st_bus_wait) begin
         wr_num  = ir[cpu_pkg::fld_a_lo +: 4];
         wr_data = bus.rd_data;
         wr_en   = is_load_ir && !busy;
      end else if (state == cpu_pkg::st_execute && !busy) begin
         if (is_alu) begin
            wr_en = alu_op != cpu_pkg::alu_cp;   // CP only sets flags
         end else if (op == cpu_pkg::op_imm_lo) begin
            wr_en   = 1'b1;
            wr_data = {rd_data_a[15:8], ins[7:0]};
         end else if (op == cpu_pkg::op_imm_hi) begin
            wr_en   = 1'b1;
            wr_data = {ins[7:0], rd_data_a[7:0]};
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= cpu_pkg::st_bus_wait;   // idle bus wait issues the first fetch
         pc      <= '0;
         flags   <= '0;
         ir      <= '0;
         bus.run <= 1'b0;
      end else begin
         case (state)
            cpu_pkg::st_fetch_wait: begin
               state <= cpu_pkg::st_execute;
            end
            cpu_pkg::st_execute: begin
               if (!busy) begin
                  if (is_halt) begin
                     state <= cpu_pkg::st_halted;
                  end else begin
                     pc <= pc_next;
                     if (is_alu) begin
                        flags <= alu_flags;
                     end
                     if (is_mem) begin
                        ir          <= ins;
                        bus.addr    <= rd_data_b;
                        bus.cmd     <= cpu_pkg::bus_cmd_t'(ins[cpu_pkg::fld_cmd_lo +: 3]);
                        bus.wr_data <= rd_data_a;
                        bus.run     <= ~bus.run;
                        state       <= cpu_pkg::st_bus_wait;
                     end else begin
                        bus.addr <= pc_next;    // next fetch
                        bus.cmd  <= cpu_pkg::bus_cmd_read_w;
                        bus.run  <= ~bus.run;
                        state    <= cpu_pkg::st_fetch_wait;
                     end
                  end
               end
            end
            cpu_pkg::st_bus_wait: begin
               if (!busy) begin
                  bus.addr <= pc;
                  bus.cmd  <= cpu_pkg::bus_cmd_read_w;
                  bus.run  <= ~bus.run;
                  state    <= cpu_pkg::st_fetch_wait;
               end
            end
            default: begin
               state <= cpu_pkg::st_halted;    // stays until reset
            end
         endcase
      end
   end

endmodule

/* logic/h80_top.sv */
`timescale 1ns/1ps

module h80_top #(
   parameter int mem_words = 4096
) (
   input  logic               clk,
   input  logic               reset,
   input  logic               load_we,
   input  cpu_pkg::bus_addr_t load_addr,
   input  cpu_pkg::word_t     load_data,
   input  cpu_pkg::reg_num_t  dbg_sel,
   output cpu_pkg::word_t     dbg_data,
   output cpu_pkg::flags_t    flags,
   output logic               halted
);

   cpu_pkg::reg_num_t rd_num_a;
   cpu_pkg::reg_num_t rd_num_b;
   cpu_pkg::reg_num_t wr_num;
   cpu_pkg::word_t    rd_data_a;
   cpu_pkg::word_t    rd_data_b;
   cpu_pkg::word_t    wr_data;
   logic              wr_en;
   cpu_pkg::alu_op_t  alu_op;
   cpu_pkg::word_t    alu_result;
   cpu_pkg::flags_t   alu_flags;

   mem_bus_if bus ();

   cpu_sequencer seq (
      .clk, .reset, .bus(bus.requester),
      .rd_num_a, .rd_num_b, .wr_num, .rd_data_a, .rd_data_b,
      .wr_en, .wr_data, .alu_op, .alu_result, .alu_flags,
      .flags, .halted
   );

   reg_file regs (
      .clk, .reset, .rd_num_a, .rd_num_b, .dbg_sel,
      .rd_data_a, .rd_data_b, .dbg_data,
      .wr_en, .wr_num, .wr_data
   );

   // carry for ADC and SBC comes from the flag register
   alu alu0 (
      .op(alu_op), .a(rd_data_a), .b(rd_data_b),
      .carry_in(flags[cpu_pkg::flag_carry]),
      .result(alu_result), .flags_out(alu_flags)
   );

   word_memory #(.mem_words(mem_words)) mem (
      .clk, .reset, .bus(bus.responder),
      .load_we, .load_addr, .load_data
   );

endmodule

/* logic/mem_bus_if.sv */
`timescale 1ns/1ps

// run toggles to start a request, done toggles when it is served
interface mem_bus_if;

   cpu_pkg::bus_addr_t addr;
   cpu_pkg::bus_cmd_t  cmd;
   cpu_pkg::word_t     wr_data;
   cpu_pkg::word_t     rd_data;
   logic               run;
   logic               done;

   modport requester (
      output addr, cmd, wr_data, run,
      input  rd_data, done
   );

   modport responder (
      input  addr, cmd, wr_data, run,
      output rd_data, done
   );

endinterface

/* logic/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
   input  logic              clk,
   input  logic              reset,
   input  cpu_pkg::reg_num_t rd_num_a,
   input  cpu_pkg::reg_num_t rd_num_b,
   input  cpu_pkg::reg_num_t dbg_sel,
   output cpu_pkg::word_t    rd_data_a,
   output cpu_pkg::word_t    rd_data_b,
   output cpu_pkg::word_t    dbg_data,
   input  logic              wr_en,
   input  cpu_pkg::reg_num_t wr_num,
   input  cpu_pkg::word_t    wr_data
);

   cpu_pkg::word_t regs [cpu_pkg::num_regs];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < cpu_pkg::num_regs; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_num] <= wr_data;
      end
   end

   // reads see the value before a write on the same edge
   assign rd_data_a = regs[rd_num_a];
   assign rd_data_b = regs[rd_num_b];
   assign dbg_data  = regs[dbg_sel];

endmodule

/* logic/word_memory.sv */
`timescale 1ns/1ps

module word_memory #(
   parameter int mem_words = 4096
) (
   input  logic               clk,
   input  logic               reset,
   mem_bus_if.responder       bus,
   input  logic               load_we,
   input  cpu_pkg::bus_addr_t load_addr,
   input  cpu_pkg::word_t     load_data
);

   localparam int idx_w = $clog2(mem_words);

   cpu_pkg::word_t   mem [mem_words];
   logic [idx_w-1:0] bus_idx;
   logic [idx_w-1:0] load_idx;
   logic             req;

   assign bus_idx  = bus.addr[idx_w:1];    // word index, bit 0 ignored
   assign load_idx = load_addr[idx_w:1];
   assign req      = bus.run != bus.done;

   always_ff @(posedge clk) begin
      if (reset) begin
         bus.done <= 1'b0;
      end else if (req) begin
         bus.done <= ~bus.done;
      end
   end

   always_ff @(posedge clk) begin
      if (load_we) begin
         mem[load_idx] <= load_data;
      end else if (req && !reset && bus.cmd == cpu_pkg::bus_cmd_write_w) begin
         mem[bus_idx] <= bus.wr_data;
      end
      if (req && bus.cmd == cpu_pkg::bus_cmd_read_w) begin
         bus.rd_data <= mem[bus_idx];   // same edge as done
      end
   end

endmodule
